// File: rtl/mini900_consts.svh
/*
 * Shared constants for the mini900 core: sizes and the 4-bit opcodes.
 * Include wherever an opcode or a width is needed.
 */
`ifndef MINI900_CONSTS_SVH
`define MINI900_CONSTS_SVH

`define MINI900_REGS 8
`define MINI900_AW 24
`define MINI900_DW 16

// opcode field, instruction bits 15:12
`define MINI900_OP_LDI  4'h0
`define MINI900_OP_LDIH 4'h1
`define MINI900_OP_LD   4'h2
`define MINI900_OP_ST   4'h3
`define MINI900_OP_DJNZ 4'h4
`define MINI900_OP_JR   4'h5
`define MINI900_OP_JRZ  4'h6
// ALU group, low three bits select the ALU operation
`define MINI900_OP_ADD  4'h8
`define MINI900_OP_SUB  4'h9
`define MINI900_OP_AND  4'ha
`define MINI900_OP_OR   4'hb
`define MINI900_OP_XOR  4'hc
`define MINI900_OP_HALT 4'hf

`endif

// File: rtl/mini900_pkg.sv
/*
 * Types shared by the mini900 blocks. Refer to them with scoped names,
 * e.g. mini900_pkg::word_t. Widths come from the constants header.
 */
`default_nettype none

`include "mini900_consts.svh"

package mini900_pkg;

    // data or instruction word
    typedef logic [`MINI900_DW-1:0] word_t;

    // byte address on the RAM port, also used for word indexes
    typedef logic [`MINI900_AW-1:0] addr_t;

    typedef logic [$clog2(`MINI900_REGS)-1:0] regsel_t;

    typedef logic [3:0] opcode_t;

    // {Z, C, V, S}
    typedef logic [3:0] flags_t;

    // controller sequence
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb,
        st_halt
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/mini900_alu.sv
/*
 * Operation unit for ADD, SUB, AND, OR and XOR on two 16-bit operands.
 * The result is combinational; the Z, C, V and S flags are stored
 * only on cycles where flag_we is set.
 */
`timescale 1ns/100ps
`default_nettype none

module mini900_alu(
    input  wire                   clk,
    input  wire                   cen,
    input  wire                   arst_n,

    input  wire  [2:0]            alu_op,
    input  mini900_pkg::word_t    a,
    input  mini900_pkg::word_t    b,
    input  wire                   flag_we,
    output mini900_pkg::word_t    result,
    output mini900_pkg::flags_t   flags
);

    // low three opcode bits
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;

    logic [16:0] sum;
    logic        carry, ovf;

    always_comb begin
        sum    = 17'd0;
        carry  = 1'b0;
        ovf    = 1'b0;
        result = a;
        case (alu_op)
            alu_add: begin
                sum    = {1'b0, a} + {1'b0, b};
                result = sum[15:0];
                carry  = sum[16];
                ovf    = a[15] == b[15] && result[15] != a[15];
            end
            alu_sub: begin
                // bit 16 is the borrow
                sum    = {1'b0, a} - {1'b0, b};
                result = sum[15:0];
                carry  = sum[16];
                ovf    = a[15] != b[15] && result[15] != a[15];
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            default: result = a;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (cen && flag_we) begin
            flags <= {result == 16'd0, carry, ovf, result[15]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/mini900_regs.sv
/*
 * Register bank: eight 16-bit registers with two combinational read
 * ports, one write port and a byte-wide dump port for inspection.
 */
`timescale 1ns/100ps
`default_nettype none

`include "mini900_consts.svh"

module mini900_regs(
    input  wire                   clk,
    input  wire                   cen,
    input  wire                   arst_n,

    input  mini900_pkg::regsel_t  rd_sel,
    input  mini900_pkg::regsel_t  rs_sel,
    input  mini900_pkg::regsel_t  reg_wsel,
    input  wire                   reg_we,
    input  mini900_pkg::word_t    reg_wdata,
    output mini900_pkg::word_t    rd_val,
    output mini900_pkg::word_t    rs_val,

    input  wire  [7:0]            dmp_addr,
    output logic [7:0]            dmp_din
);

    mini900_pkg::word_t regs_q [`MINI900_REGS];
    mini900_pkg::word_t dmp_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MINI900_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (cen && reg_we) begin
            regs_q[reg_wsel] <= reg_wdata;
        end
    end

    assign rd_val = regs_q[rd_sel];
    assign rs_val = regs_q[rs_sel];

    // dump: bits 3:1 pick the register, bit 0 the byte
    assign dmp_word = regs_q[dmp_addr[3:1]];

    always_comb begin
        if (dmp_addr[7:4] != 4'd0) begin
            // outside the register area
            dmp_din = 8'h00;
        end else begin
            dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/mini900_ramctl.sv
/*
 * RAM controller. Registers the byte address from pc or the pointer,
 * drives the store strobes and returns read data with a one-cycle rdy
 * pulse, two enabled cycles after the request.
 */
`timescale 1ns/100ps
`default_nettype none

module mini900_ramctl(
    input  wire                 clk,
    input  wire                 cen,
    input  wire                 arst_n,

    input  wire                 ram_ren,
    input  wire                 ram_wen,
    input  wire                 use_ptr,
    input  mini900_pkg::addr_t  pc,
    input  mini900_pkg::addr_t  ptr,
    input  mini900_pkg::word_t  wdata,
    output mini900_pkg::word_t  rdata,
    output logic                rdy,

    output mini900_pkg::addr_t  ram_addr,
    input  mini900_pkg::word_t  ram_dout,
    output mini900_pkg::word_t  ram_din,
    output logic [1:0]          ram_we
);

    mini900_pkg::addr_t word_idx;
    mini900_pkg::word_t hold_q;
    logic               rd_pend;
    logic [1:0]         we_q;

    assign word_idx = use_ptr ? ptr : pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_addr <= '0;
            ram_din  <= '0;
            hold_q   <= '0;
            rd_pend  <= 1'b0;
            rdy      <= 1'b0;
            we_q     <= 2'b00;
        end else if (cen) begin
            if (ram_ren || ram_wen) begin
                // word index to byte address
                ram_addr <= {word_idx[22:0], 1'b0};
            end
            if (ram_wen) begin
                ram_din <= wdata;
            end
            // memory answers one cycle after the address
            rd_pend <= ram_ren;
            rdy     <= rd_pend;
            we_q    <= {2{ram_wen}};
            if (rdy) begin
                hold_q <= ram_dout;
            end
        end
    end

    // fresh data while rdy is up, last read otherwise
    assign rdata  = rdy ? ram_dout : hold_q;
    assign ram_we = we_q & {2{cen}};

endmodule

`default_nettype wire

// File: rtl/mini900_ctrl.sv
/*
 * Instruction controller. Runs fetch, decode and execute one instruction
 * at a time, keeps the program counter and resolves relative branches.
 * pc is a word index; the RAM controller turns it into a byte address.
 */
`timescale 1ns/100ps
`default_nettype none

`include "mini900_consts.svh"

module mini900_ctrl(
    input  wire                   clk,
    input  wire                   cen,
    input  wire                   arst_n,

    input  mini900_pkg::word_t    rdata,
    input  wire                   rdy,
    output logic                  ram_ren,
    output logic                  ram_wen,
    output logic                  use_ptr,
    output mini900_pkg::addr_t    pc,
    output mini900_pkg::addr_t    ptr,
    output mini900_pkg::word_t    wdata,

    output mini900_pkg::regsel_t  rd_sel,
    output mini900_pkg::regsel_t  rs_sel,
    output mini900_pkg::regsel_t  reg_wsel,
    output logic                  reg_we,
    output mini900_pkg::word_t    reg_wdata,
    input  mini900_pkg::word_t    rd_val,
    input  mini900_pkg::word_t    rs_val,

    output logic [2:0]            alu_op,
    output logic                  flag_we,
    input  mini900_pkg::word_t    result,
    input  mini900_pkg::flags_t   flags,
    output logic                  halt
);

    mini900_pkg::ctrl_state_t state;
    mini900_pkg::word_t       ir;
    mini900_pkg::opcode_t     opc;
    logic [7:0]               imm8;
    mini900_pkg::addr_t       imm_ext;
    mini900_pkg::word_t       dec_val;
    logic                     is_alu, is_mem, take;

    // instruction fields
    assign opc      = ir[15:12];
    assign imm8     = ir[7:0];
    assign imm_ext  = {{16{imm8[7]}}, imm8};
    assign rd_sel   = ir[10:8];
    assign rs_sel   = ir[6:4];
    assign reg_wsel = ir[10:8];
    assign dec_val  = rd_val - 16'd1;

    assign is_alu = opc == `MINI900_OP_ADD || opc == `MINI900_OP_SUB ||
                    opc == `MINI900_OP_AND || opc == `MINI900_OP_OR  ||
                    opc == `MINI900_OP_XOR;
    assign is_mem = opc == `MINI900_OP_LD || opc == `MINI900_OP_ST;

    assign alu_op  = opc[2:0];
    assign flag_we = state == mini900_pkg::st_exec && is_alu;
    assign halt    = state == mini900_pkg::st_halt;

    // memory requests: fetch from pc, loads and stores through rs
    assign ram_ren = state == mini900_pkg::st_fetch ||
                     (state == mini900_pkg::st_exec && opc == `MINI900_OP_LD);
    assign ram_wen = state == mini900_pkg::st_exec && opc == `MINI900_OP_ST;
    assign use_ptr = state == mini900_pkg::st_exec;
    assign ptr     = {8'h00, rs_val};
    assign wdata   = rd_val;

    // branch condition
    always_comb begin
        case (opc)
            `MINI900_OP_DJNZ: take = dec_val != 16'd0;
            `MINI900_OP_JR:   take = 1'b1;
            `MINI900_OP_JRZ:  take = flags[3];
            default:          take = 1'b0;
        endcase
    end

    // write-back value selection
    always_comb begin
        reg_we    = 1'b0;
        reg_wdata = result;
        if (state == mini900_pkg::st_exec) begin
            case (opc)
                `MINI900_OP_LDI: begin
                    reg_we    = 1'b1;
                    reg_wdata = {8'h00, imm8};
                end
                `MINI900_OP_LDIH: begin
                    reg_we    = 1'b1;
                    reg_wdata = {imm8, rd_val[7:0]};
                end
                `MINI900_OP_DJNZ: begin
                    reg_we    = 1'b1;
                    reg_wdata = dec_val;
                end
                default: reg_we = is_alu;
            endcase
        end else if (state == mini900_pkg::st_wb && opc == `MINI900_OP_LD) begin
            // load data arrives with rdy
            reg_we    = rdy;
            reg_wdata = rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mini900_pkg::st_fetch;
            pc    <= '0;
            ir    <= '0;
        end else if (cen) begin
            case (state)
                mini900_pkg::st_fetch: state <= mini900_pkg::st_decode;
                mini900_pkg::st_decode: begin
                    if (rdy) begin
                        ir    <= rdata;
                        pc    <= pc + 24'd1;
                        state <= mini900_pkg::st_exec;
                    end
                end
                mini900_pkg::st_exec: begin
                    // pc already points past this instruction
                    if (take) begin
                        pc <= pc + imm_ext;
                    end
                    if (opc == `MINI900_OP_HALT) begin
                        state <= mini900_pkg::st_halt;
                    end else if (is_mem) begin
                        state <= mini900_pkg::st_mem;
                    end else begin
                        state <= mini900_pkg::st_fetch;
                    end
                end
                mini900_pkg::st_mem: state <= mini900_pkg::st_wb;
                mini900_pkg::st_wb: begin
                    if (rdy || opc == `MINI900_OP_ST) begin
                        state <= mini900_pkg::st_fetch;
                    end
                end
                mini900_pkg::st_halt: state <= mini900_pkg::st_halt;
                default: state <= mini900_pkg::st_fetch;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/mini900.sv
/*
 * mini900 core top level. Connects the controller, register bank, ALU
 * and RAM controller. Drive cen to advance the core; registers can be
 * read back through the dump port at any time.
 */
`timescale 1ns/100ps
`default_nettype none

module mini900(
    input  wire                  clk,
    input  wire                  cen,
    input  wire                  arst_n,

    output mini900_pkg::addr_t   ram_addr,
    input  mini900_pkg::word_t   ram_dout,
    output mini900_pkg::word_t   ram_din,
    output logic [1:0]           ram_we,

    // register dump
    input  wire  [7:0]           dmp_addr,
    output logic [7:0]           dmp_din,
    output logic                 halt
);

    // controller to RAM controller
    logic                ram_ren, ram_wen, use_ptr;
    mini900_pkg::addr_t  pc, ptr;
    mini900_pkg::word_t  wdata, rdata;
    logic                rdy;

    // register bank
    mini900_pkg::regsel_t rd_sel, rs_sel, reg_wsel;
    logic                 reg_we;
    mini900_pkg::word_t   reg_wdata, rd_val, rs_val;

    // ALU
    logic [2:0]          alu_op;
    logic                flag_we;
    mini900_pkg::word_t  result;
    mini900_pkg::flags_t flags;

    mini900_ctrl u_ctrl(
        .clk        ( clk        ),
        .cen        ( cen        ),
        .arst_n     ( arst_n     ),
        .rdata      ( rdata      ),
        .rdy        ( rdy        ),
        .ram_ren    ( ram_ren    ),
        .ram_wen    ( ram_wen    ),
        .use_ptr    ( use_ptr    ),
        .pc         ( pc         ),
        .ptr        ( ptr        ),
        .wdata      ( wdata      ),
        .rd_sel     ( rd_sel     ),
        .rs_sel     ( rs_sel     ),
        .reg_wsel   ( reg_wsel   ),
        .reg_we     ( reg_we     ),
        .reg_wdata  ( reg_wdata  ),
        .rd_val     ( rd_val     ),
        .rs_val     ( rs_val     ),
        .alu_op     ( alu_op     ),
        .flag_we    ( flag_we    ),
        .result     ( result     ),
        .flags      ( flags      ),
        .halt       ( halt       )
    );

    mini900_regs u_regs(
        .clk        ( clk        ),
        .cen        ( cen        ),
        .arst_n     ( arst_n     ),
        .rd_sel     ( rd_sel     ),
        .rs_sel     ( rs_sel     ),
        .reg_wsel   ( reg_wsel   ),
        .reg_we     ( reg_we     ),
        .reg_wdata  ( reg_wdata  ),
        .rd_val     ( rd_val     ),
        .rs_val     ( rs_val     ),
        .dmp_addr   ( dmp_addr   ),
        .dmp_din    ( dmp_din    )
    );

    mini900_alu u_alu(
        .clk        ( clk        ),
        .cen        ( cen        ),
        .arst_n     ( arst_n     ),
        .alu_op     ( alu_op     ),
        .a          ( rd_val     ),
        .b          ( rs_val     ),
        .flag_we    ( flag_we    ),
        .result     ( result     ),
        .flags      ( flags      )
    );

    mini900_ramctl u_ramctl(
        .clk        ( clk        ),
        .cen        ( cen        ),
        .arst_n     ( arst_n     ),
        .ram_ren    ( ram_ren    ),
        .ram_wen    ( ram_wen    ),
        .use_ptr    ( use_ptr    ),
        .pc         ( pc         ),
        .ptr        ( ptr        ),
        .wdata      ( wdata      ),
        .rdata      ( rdata      ),
        .rdy        ( rdy        ),
        .ram_addr   ( ram_addr   ),
        .ram_dout   ( ram_dout   ),
        .ram_din    ( ram_din    ),
        .ram_we     ( ram_we     )
    );

endmodule

`default_nettype wire

// File: testbench/mini900_checker.sv
/*
 * Concurrent assertions on the mini900 controller, attached by bind.
 * Failures raise $error and are counted in fail_count for the testbench.
 */
`timescale 1ns/100ps
`default_nettype none

module mini900_checker(
    input  wire                       clk,
    input  wire                       cen,
    input  wire                       arst_n,
    input  wire                       ram_ren,
    input  wire                       ram_wen,
    input  wire                       halt,
    input  mini900_pkg::ctrl_state_t  state
);

    int fail_count = 0;

    // one memory request kind at a time
    a_req_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(ram_ren && ram_wen))
        else begin
            $error("fetch or load requested together with a store");
            fail_count++;
        end

    // halted core stays off the bus
    a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        halt |-> !ram_ren && !ram_wen)
        else begin
            $error("memory request issued while halted");
            fail_count++;
        end

    // frozen while cen is low
    a_cen_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !cen |=> state == $past(state))
        else begin
            $error("controller state moved with cen low");
            fail_count++;
        end

endmodule

bind mini900_ctrl mini900_checker u_checker(
    .clk     ( clk     ),
    .cen     ( cen     ),
    .arst_n  ( arst_n  ),
    .ram_ren ( ram_ren ),
    .ram_wen ( ram_wen ),
    .halt    ( halt    ),
    .state   ( state   )
);

`default_nettype wire

// File: testbench/mini900_mon.sv
/*
 * Checks module for the mini900 testbench. Takes the memory image word
 * by word, runs an ISA reference model on model_run, then compares the
 * dumped register bytes, halt and memory words presented to it.
 */
`timescale 1ns/100ps
`default_nettype none

`include "mini900_consts.svh"

module mini900_mon(
    input  wire                 clk,
    input  wire                 img_we,
    input  wire  [15:0]         img_addr,
    input  mini900_pkg::word_t  img_data,
    input  wire                 model_clr,
    input  wire                 model_run,
    input  wire                 dmp_chk,
    input  wire  [7:0]          dmp_addr,
    input  wire  [7:0]          dmp_din,
    input  wire                 halt,
    input  wire                 mem_chk,
    input  wire  [15:0]         mem_addr,
    input  mini900_pkg::word_t  mem_data,
    output int                  err_count
);

    mini900_pkg::word_t mmem [0:65535];
    mini900_pkg::word_t mreg [0:7];
    logic [3:0]         mflags;
    logic               m_halted = 1'b0;
    int                 errors = 0;
    logic [7:0]         exp_byte;

    assign err_count = errors;

    // runs the program from word 0, returns 1 once HALT is reached
    function automatic logic run_reference();
        logic [15:0]        pc;
        mini900_pkg::word_t ins, a, b, res;
        logic [3:0]         op;
        logic [2:0]         rd, rs;
        logic [15:0]        rel;
        int                 ures, sres, steps;
        logic               c, done;
        pc = 16'd0;
        done = 1'b0;
        steps = 0;
        mflags = 4'd0;
        for (int i = 0; i < 8; i++) begin
            mreg[i] = 16'd0;
        end
        while (!done && steps < 10000) begin
            ins = mmem[pc];
            pc = pc + 16'd1;
            steps++;
            op = ins[15:12];
            rd = ins[10:8];
            rs = ins[6:4];
            rel = {{8{ins[7]}}, ins[7:0]};
            a = mreg[rd];
            b = mreg[rs];
            case (op)
                `MINI900_OP_LDI:  mreg[rd] = {8'h00, ins[7:0]};
                `MINI900_OP_LDIH: mreg[rd] = {ins[7:0], a[7:0]};
                `MINI900_OP_LD:   mreg[rd] = mmem[b];
                `MINI900_OP_ST:   mmem[b] = a;
                `MINI900_OP_DJNZ: begin
                    res = a - 16'd1;
                    mreg[rd] = res;
                    if (res != 16'd0) begin
                        pc = pc + rel;
                    end
                end
                `MINI900_OP_JR:   pc = pc + rel;
                `MINI900_OP_JRZ: begin
                    if (mflags[3]) begin
                        pc = pc + rel;
                    end
                end
                `MINI900_OP_ADD, `MINI900_OP_SUB: begin
                    if (op == `MINI900_OP_ADD) begin
                        ures = int'(a) + int'(b);
                        sres = int'($signed(a)) + int'($signed(b));
                        c = ures > 65535;
                    end else begin
                        // borrow when the unsigned difference goes negative
                        ures = int'(a) - int'(b);
                        sres = int'($signed(a)) - int'($signed(b));
                        c = ures < 0;
                    end
                    res = ures[15:0];
                    mreg[rd] = res;
                    mflags = {res == 16'd0, c, sres > 32767 || sres < -32768, res[15]};
                end
                `MINI900_OP_AND, `MINI900_OP_OR, `MINI900_OP_XOR: begin
                    if (op == `MINI900_OP_AND) begin
                        res = a & b;
                    end else if (op == `MINI900_OP_OR) begin
                        res = a | b;
                    end else begin
                        res = a ^ b;
                    end
                    mreg[rd] = res;
                    mflags = {res == 16'd0, 2'b00, res[15]};
                end
                `MINI900_OP_HALT: done = 1'b1;
                default: ;
            endcase
        end
        return done;
    endfunction

    always @(posedge clk) begin
        if (img_we) begin
            mmem[img_addr] = img_data;
        end
        if (model_clr) begin
            for (int i = 0; i < 8; i++) begin
                mreg[i] = 16'd0;
            end
            m_halted = 1'b0;
        end
        if (model_run) begin
            m_halted = run_reference();
            if (!m_halted) begin
                $display("reference model ran out of steps without reaching HALT");
                errors++;
            end
        end
        if (dmp_chk) begin
            exp_byte = dmp_addr[0] ? mreg[dmp_addr[3:1]][15:8] : mreg[dmp_addr[3:1]][7:0];
            if (dmp_din !== exp_byte) begin
                $display("ERROR %0t: r%0d %s byte reads %h, model %h", $time,
                         dmp_addr[3:1], dmp_addr[0] ? "high" : "low", dmp_din, exp_byte);
                errors++;
            end
            if (halt !== m_halted) begin
                $display("ERROR %0t: halt is %b, model %b", $time, halt, m_halted);
                errors++;
            end
        end
        if (mem_chk && mem_data !== mmem[mem_addr]) begin
            $display("ERROR %0t: memory word %h holds %h, model %h", $time,
                     mem_addr, mem_data, mmem[mem_addr]);
            errors++;
        end
    end

endmodule

`default_nettype wire

// File: testbench/mini900_tb.sv
/*
 * Testbench for the mini900 core. Builds small programs with an LFSR,
 * runs them on the DUT against a word RAM model and hands the results
 * to mini900_mon for comparison. Ends with a summary of all errors.
 */
`timescale 1ns/100ps
`default_nettype none

`include "mini900_consts.svh"

module mini900_tb;

    localparam logic [15:0] win_base = 16'h4000;
    localparam int halt_limit = 2000;

    logic                clk, cen, arst_n, halt;
    mini900_pkg::addr_t  ram_addr;
    mini900_pkg::word_t  ram_dout, ram_din;
    logic [1:0]          ram_we;
    logic [7:0]          dmp_addr, dmp_din;

    // monitor side
    logic                img_we, model_clr, model_run, dmp_chk, mem_chk;
    logic [15:0]         img_addr, mem_addr;
    mini900_pkg::word_t  img_data, mem_data;
    int                  mon_errors;
    int                  timeouts = 0;

    mini900_pkg::word_t  mem [0:65535];
    mini900_pkg::word_t  prog[$];
    mini900_pkg::word_t  rnd_prog[$];
    logic [15:0]         lfsr = 16'd15915;

    mini900 u_dut(
        .clk      ( clk      ),
        .cen      ( cen      ),
        .arst_n   ( arst_n   ),
        .ram_addr ( ram_addr ),
        .ram_dout ( ram_dout ),
        .ram_din  ( ram_din  ),
        .ram_we   ( ram_we   ),
        .dmp_addr ( dmp_addr ),
        .dmp_din  ( dmp_din  ),
        .halt     ( halt     )
    );

    mini900_mon u_mon(
        .clk       ( clk        ),
        .img_we    ( img_we     ),
        .img_addr  ( img_addr   ),
        .img_data  ( img_data   ),
        .model_clr ( model_clr  ),
        .model_run ( model_run  ),
        .dmp_chk   ( dmp_chk    ),
        .dmp_addr  ( dmp_addr   ),
        .dmp_din   ( dmp_din    ),
        .halt      ( halt       ),
        .mem_chk   ( mem_chk    ),
        .mem_addr  ( mem_addr   ),
        .mem_data  ( mem_data   ),
        .err_count ( mon_errors )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // word RAM, registered read, byte write strobes
    always @(posedge clk) begin
        if (cen) begin
            ram_dout <= mem[ram_addr[16:1]];
        end
        if (ram_we[0]) begin
            mem[ram_addr[16:1]][7:0] <= ram_din[7:0];
        end
        if (ram_we[1]) begin
            mem[ram_addr[16:1]][15:8] <= ram_din[15:8];
        end
    end

    // fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [15:0] next_bits(input int n);
        logic [15:0] val;
        logic        fb;
        val = 16'd0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val = {val[14:0], fb};
        end
        return val;
    endfunction

    function automatic mini900_pkg::word_t fill_word(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic mini900_pkg::word_t imm_instr(input logic [3:0] op,
                                                     input logic [2:0] rd,
                                                     input logic [7:0] imm);
        return {op, 1'b0, rd, imm};
    endfunction

    function automatic mini900_pkg::word_t reg_instr(input logic [3:0] op,
                                                     input logic [2:0] rd,
                                                     input logic [2:0] rs);
        return {op, 1'b0, rd, 1'b0, rs, 4'h0};
    endfunction

    task automatic apply_reset();
        arst_n = 1'b0;
        cen = 1'b0;
        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;
    endtask

    task automatic write_word(input logic [15:0] a, input mini900_pkg::word_t d);
        mem[a] = d;
        img_we = 1'b1;
        img_addr = a;
        img_data = d;
        @(posedge clk);
        #2 img_we = 1'b0;
    endtask

    task automatic sweep_results(input logic with_mem);
        for (int i = 0; i < 16; i++) begin
            dmp_addr = 8'(i);
            dmp_chk = 1'b1;
            @(posedge clk);
            #2;
        end
        dmp_chk = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem_addr = win_base + 16'(i);
            mem_data = mem[mem_addr];
            mem_chk = with_mem;
            @(posedge clk);
            #2;
        end
        mem_chk = 1'b0;
    endtask

    task automatic wait_for_halt(input logic toggle_cen);
        int cycles;
        cycles = 0;
        while (!halt && cycles < halt_limit) begin
            cen = toggle_cen ? next_bits(1) != 16'd0 : 1'b1;
            @(posedge clk);
            #2;
            cycles++;
        end
        cen = 1'b1;
        if (!halt) begin
            $display("core never halted within %0d cycles", halt_limit);
            timeouts++;
        end
    endtask

    // reset, load window and program, run the model, then the DUT
    task automatic run_program(input logic toggle_cen);
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            write_word(win_base + 16'(i), fill_word(win_base + 16'(i)));
        end
        for (int i = 0; i < prog.size(); i++) begin
            write_word(16'(i), prog[i]);
        end
        model_run = 1'b1;
        @(posedge clk);
        #2 model_run = 1'b0;
        wait_for_halt(toggle_cen);
        sweep_results(1'b1);
    endtask

    function automatic void random_alu_prog();
        logic [2:0] kind, rd, rs;
        logic [7:0] imm;
        prog.delete();
        for (int i = 0; i < 40; i++) begin
            kind = 3'(next_bits(3));
            rd = 3'(next_bits(3));
            rs = 3'(next_bits(3));
            imm = 8'(next_bits(8));
            case (kind)
                3'd0: prog.push_back(imm_instr(`MINI900_OP_LDI, rd, imm));
                3'd1: prog.push_back(imm_instr(`MINI900_OP_LDIH, rd, imm));
                3'd3: prog.push_back(reg_instr(`MINI900_OP_SUB, rd, rs));
                3'd4: prog.push_back(reg_instr(`MINI900_OP_AND, rd, rs));
                3'd5: prog.push_back(reg_instr(`MINI900_OP_OR, rd, rs));
                3'd6: prog.push_back(reg_instr(`MINI900_OP_XOR, rd, rs));
                default: prog.push_back(reg_instr(`MINI900_OP_ADD, rd, rs));
            endcase
        end
        prog.push_back({`MINI900_OP_HALT, 12'h000});
    endfunction

    function automatic void store_load_prog();
        logic [3:0]         slot;
        mini900_pkg::word_t val;
        slot = 4'(next_bits(4));
        val = next_bits(16);
        prog.delete();
        // r1 points into the window
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd1, win_base[7:0] | {4'h0, slot}));
        prog.push_back(imm_instr(`MINI900_OP_LDIH, 3'd1, win_base[15:8]));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd2, val[7:0]));
        prog.push_back(imm_instr(`MINI900_OP_LDIH, 3'd2, val[15:8]));
        prog.push_back(reg_instr(`MINI900_OP_ST, 3'd2, 3'd1));
        prog.push_back(reg_instr(`MINI900_OP_LD, 3'd3, 3'd1));
        prog.push_back({`MINI900_OP_HALT, 12'h000});
    endfunction

    function automatic void djnz_loop_prog();
        logic [7:0] n;
        n = 8'(1 + int'(next_bits(5)) % 20);
        prog.delete();
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd0, n));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd1, 8'h00));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd2, 8'(next_bits(8))));
        prog.push_back(reg_instr(`MINI900_OP_ADD, 3'd1, 3'd2));
        // back to the ADD, two words before the next instruction
        prog.push_back(imm_instr(`MINI900_OP_DJNZ, 3'd0, 8'hfe));
        prog.push_back({`MINI900_OP_HALT, 12'h000});
    endfunction

    function automatic void jrz_skip_prog();
        logic [7:0] a, b;
        a = 8'(next_bits(8));
        b = 8'(next_bits(8));
        if (b == a) begin
            b = a + 8'd1;
        end
        prog.delete();
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd1, a));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd2, a));
        prog.push_back(reg_instr(`MINI900_OP_SUB, 3'd1, 3'd2));
        prog.push_back(imm_instr(`MINI900_OP_JRZ, 3'd0, 8'h01));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd3, 8'h55));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd4, a));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd5, b));
        prog.push_back(reg_instr(`MINI900_OP_SUB, 3'd4, 3'd5));
        prog.push_back(imm_instr(`MINI900_OP_JRZ, 3'd0, 8'h01));
        prog.push_back(imm_instr(`MINI900_OP_LDI, 3'd6, 8'h66));
        prog.push_back({`MINI900_OP_HALT, 12'h000});
    endfunction

    initial begin
        arst_n = 1'b0;
        cen = 1'b0;
        ram_dout = 16'd0;
        dmp_addr = 8'd0;
        img_we = 1'b0;
        img_addr = 16'd0;
        img_data = 16'd0;
        model_clr = 1'b0;
        model_run = 1'b0;
        dmp_chk = 1'b0;
        mem_chk = 1'b0;
        mem_addr = 16'd0;
        mem_data = 16'd0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = fill_word(16'(i));
        end

        // dump right after reset, cen never high yet
        apply_reset();
        model_clr = 1'b1;
        @(posedge clk);
        #2 model_clr = 1'b0;
        sweep_results(1'b0);

        random_alu_prog();
        rnd_prog = prog;
        run_program(1'b0);
        store_load_prog();
        run_program(1'b0);
        djnz_loop_prog();
        run_program(1'b0);
        jrz_skip_prog();
        run_program(1'b0);
        // same random program, cen toggling
        prog = rnd_prog;
        run_program(1'b1);

        $display("summary: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mon_errors, timeouts, u_dut.u_ctrl.u_checker.fail_count);
        if (mon_errors == 0 && timeouts == 0 && u_dut.u_ctrl.u_checker.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mini900.f
+incdir+rtl
rtl/mini900_pkg.sv
rtl/mini900_alu.sv
rtl/mini900_regs.sv
rtl/mini900_ramctl.sv
rtl/mini900_ctrl.sv
rtl/mini900.sv
testbench/mini900_checker.sv
testbench/mini900_mon.sv
testbench/mini900_tb.sv
